/* build.f */
common/gemm_pkg.sv
hw/operand_buffer.sv
hw/dma/dma_engine.sv
hw/mm/mm_engine.sv
hw/gemm_accel_top.sv
test/mem_model.sv
test/gemm_tb.sv

/* common/gemm_pkg.sv */
// tile sizes, element/row/accumulator types
// memory bus and buffer write structs
// DMA and multiply engine state encodings
package gemm_pkg;

    // tile geometry
    localparam int TILE_N     = 4;
    localparam int ELEM_W     = 8;
    localparam int ACC_W      = 32;
    // row index into an operand buffer
    localparam int BUF_AW     = 2;
    // byte step between consecutive 32-bit words
    localparam int WORD_BYTES = 4;

    // signed operand element
    typedef logic signed [ELEM_W-1:0] elem_t;

    // one matrix row, element 0 in bits [7:0]
    typedef elem_t [TILE_N-1:0] row_t;

    // signed product accumulator
    typedef logic signed [ACC_W-1:0] acc_t;

    // result tile, [row][column]
    typedef acc_t [TILE_N-1:0][TILE_N-1:0] c_tile_t;

    // request, master to slave
    typedef struct packed {
        logic        valid;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // response, slave to master
    typedef struct packed {
        logic        ready;
        // read data, one cycle
        logic        rvalid;
        logic [31:0] rdata;
    } mem_rsp_t;

    // row write into an operand buffer
    typedef struct packed {
        logic              en;
        logic [BUF_AW-1:0] addr;
        row_t              data;
    } buf_wr_t;

    typedef enum logic [2:0] {
        DMA_IDLE,
        DMA_READ_A,
        DMA_READ_B,
        DMA_WAIT_MM,
        DMA_WRITE_C,
        DMA_DONE
    } dma_state_t;

    typedef enum logic [2:0] {
        MM_IDLE,
        MM_FETCH_A,
        MM_FETCH_B,
        MM_ACCUM,
        MM_DONE
    } mm_state_t;

endpackage

/* hw/dma/dma_engine.sv */
// DMA controller, load A and B rows, kick the multiply engine
// then store the C tile word by word
// single outstanding request on the memory bus
module dma_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [31:0]         mat_a_addr_i,
    input  logic [31:0]         mat_b_addr_i,
    input  logic [31:0]         mat_c_addr_i,
    input  logic                start_i,
    output logic                done_o,
    output gemm_pkg::mem_req_t  mem_req_o,
    input  gemm_pkg::mem_rsp_t  mem_rsp_i,
    output gemm_pkg::buf_wr_t   buf_a_wr_o,
    output gemm_pkg::buf_wr_t   buf_b_wr_o,
    output logic                mm_start_o,
    input  logic                mm_done_i,
    input  gemm_pkg::c_tile_t   c_tile_i
);
    import gemm_pkg::*;

    dma_state_t state;
    // row index in load phase, element index in store phase
    logic [2*BUF_AW-1:0] cnt;
    logic [31:0]         a_base;
    logic [31:0]         b_base;
    logic [31:0]         c_base;
    mem_req_t            req_q;
    // read accepted, data not back yet
    logic                rd_pend;
    logic                req_acc;
    logic                rd_done;
    logic                last_row;
    logic [31:0]         rd_addr;
    logic [31:0]         wr_addr;
    acc_t                c_elem;

    assign req_acc  = req_q.valid && mem_rsp_i.ready;
    assign rd_done  = rd_pend && mem_rsp_i.rvalid;
    assign last_row = cnt[BUF_AW-1:0] == BUF_AW'(TILE_N - 1);

    // row k at base + 4k
    assign rd_addr = ((state == DMA_READ_A) ? a_base : b_base)
                     + 32'(cnt[BUF_AW-1:0]) * WORD_BYTES;
    // C[i][j] at base + 4(4i + j), cnt is {i, j}
    assign wr_addr = c_base + 32'(cnt) * WORD_BYTES;
    assign c_elem  = c_tile_i[cnt[2*BUF_AW-1:BUF_AW]][cnt[BUF_AW-1:0]];

    // base addresses, sampled on an accepted start
    always_ff @(posedge clk) begin
        if (state == DMA_IDLE && start_i) begin
            a_base <= mat_a_addr_i;
            b_base <= mat_b_addr_i;
            c_base <= mat_c_addr_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= DMA_IDLE;
            cnt        <= '0;
            req_q      <= '0;
            rd_pend    <= 1'b0;
            mm_start_o <= 1'b0;
        end else begin
            mm_start_o <= 1'b0;
            // drop valid on acceptance, reads then wait for rvalid
            if (req_acc) begin
                req_q.valid <= 1'b0;
                rd_pend     <= !req_q.we;
            end
            case (state)
                DMA_IDLE: begin
                    if (start_i) begin
                        cnt   <= '0;
                        state <= DMA_READ_A;
                    end
                end
                DMA_READ_A, DMA_READ_B: begin
                    // next row read once the bus is free
                    if (!req_q.valid && !rd_pend) begin
                        req_q.valid <= 1'b1;
                        req_q.we    <= 1'b0;
                        req_q.addr  <= rd_addr;
                        req_q.wdata <= '0;
                    end
                    if (rd_done) begin
                        rd_pend <= 1'b0;
                        cnt     <= cnt + 1'b1;
                        if (last_row) begin
                            cnt <= '0;
                            if (state == DMA_READ_A) begin
                                state <= DMA_READ_B;
                            end else begin
                                // both buffers full
                                state      <= DMA_WAIT_MM;
                                mm_start_o <= 1'b1;
                            end
                        end
                    end
                end
                DMA_WAIT_MM: begin
                    if (mm_done_i) begin
                        cnt   <= '0;
                        state <= DMA_WRITE_C;
                    end
                end
                DMA_WRITE_C: begin
                    if (!req_q.valid) begin
                        req_q.valid <= 1'b1;
                        req_q.we    <= 1'b1;
                        req_q.addr  <= wr_addr;
                        req_q.wdata <= c_elem;
                    end
                    // write is complete on acceptance
                    if (req_acc) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == '1) begin
                            state <= DMA_DONE;
                        end
                    end
                end
                DMA_DONE: state <= DMA_IDLE;
                default:  state <= DMA_IDLE;
            endcase
        end
    end

    // rdata straight into the buffer of the current phase
    always_comb begin
        buf_a_wr_o.en   = rd_done && (state == DMA_READ_A);
        buf_a_wr_o.addr = cnt[BUF_AW-1:0];
        buf_a_wr_o.data = mem_rsp_i.rdata;
        buf_b_wr_o.en   = rd_done && (state == DMA_READ_B);
        buf_b_wr_o.addr = cnt[BUF_AW-1:0];
        buf_b_wr_o.data = mem_rsp_i.rdata;
    end

    assign mem_req_o = req_q;
    // one cycle in DMA_DONE
    assign done_o    = state == DMA_DONE;

    // stalled request must not move
    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_q.valid && !mem_rsp_i.ready |=> $stable(req_q));

endmodule

/* hw/gemm_accel_top.sv */
// accelerator top, DMA engine, A and B operand buffers
// and the multiply engine
module gemm_accel_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [31:0]        mat_a_addr_i,
    input  logic [31:0]        mat_b_addr_i,
    input  logic [31:0]        mat_c_addr_i,
    input  logic               start_i,
    output logic               done_o,
    output gemm_pkg::mem_req_t mem_req_o,
    input  gemm_pkg::mem_rsp_t mem_rsp_i
);
    import gemm_pkg::*;

    // DMA to buffers
    buf_wr_t           buf_a_wr;
    buf_wr_t           buf_b_wr;
    // multiply engine to buffers
    logic [BUF_AW-1:0] a_rd_addr;
    logic [BUF_AW-1:0] b_rd_addr;
    row_t              a_rd_data;
    row_t              b_rd_data;
    logic              mm_start;
    logic              mm_done;
    c_tile_t           c_tile;

    dma_engine u_dma (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr_i),
        .mat_b_addr_i (mat_b_addr_i),
        .mat_c_addr_i (mat_c_addr_i),
        .start_i      (start_i),
        .done_o       (done_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .buf_a_wr_o   (buf_a_wr),
        .buf_b_wr_o   (buf_b_wr),
        .mm_start_o   (mm_start),
        .mm_done_i    (mm_done),
        .c_tile_i     (c_tile)
    );

    operand_buffer u_buf_a (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (buf_a_wr),
        .rd_addr_i (a_rd_addr),
        .rd_data_o (a_rd_data)
    );

    operand_buffer u_buf_b (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (buf_b_wr),
        .rd_addr_i (b_rd_addr),
        .rd_data_o (b_rd_data)
    );

    mm_engine u_mm (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (mm_start),
        .a_rd_addr_o (a_rd_addr),
        .b_rd_addr_o (b_rd_addr),
        .a_rd_data_i (a_rd_data),
        .b_rd_data_i (b_rd_data),
        .c_tile_o    (c_tile),
        .done_o      (mm_done)
    );

endmodule

/* hw/mm/mm_engine.sv */
// sequential 4x4 signed multiply-accumulate engine
// reads A and B rows from the operand buffers, holds the C tile
module mm_engine (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start_i,
    output logic [gemm_pkg::BUF_AW-1:0] a_rd_addr_o,
    output logic [gemm_pkg::BUF_AW-1:0] b_rd_addr_o,
    input  gemm_pkg::row_t              a_rd_data_i,
    input  gemm_pkg::row_t              b_rd_data_i,
    output gemm_pkg::c_tile_t           c_tile_o,
    output logic                        done_o
);
    import gemm_pkg::*;

    mm_state_t         state;
    // output row i
    logic [BUF_AW-1:0] row_q;
    // inner index k, also the B row
    logic [BUF_AW-1:0] k_q;
    logic              start_ok;
    row_t              a_row_q;
    elem_t             a_elem;
    acc_t              prod [TILE_N];
    c_tile_t           c_q;

    assign start_ok = start_i && (state == MM_IDLE || state == MM_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MM_IDLE;
            row_q <= '0;
            k_q   <= '0;
        end else begin
            case (state)
                MM_IDLE, MM_DONE: begin
                    state <= MM_IDLE;
                    if (start_ok) begin
                        row_q <= '0;
                        k_q   <= '0;
                        state <= MM_FETCH_A;
                    end
                end
                MM_FETCH_A: state <= MM_FETCH_B;
                MM_FETCH_B: state <= MM_ACCUM;
                MM_ACCUM: begin
                    // k and row wrap to zero on their own
                    k_q <= k_q + 1'b1;
                    if (k_q == BUF_AW'(TILE_N - 1)) begin
                        row_q <= row_q + 1'b1;
                        if (row_q == BUF_AW'(TILE_N - 1)) begin
                            state <= MM_DONE;
                        end else begin
                            state <= MM_FETCH_A;
                        end
                    end else begin
                        state <= MM_FETCH_B;
                    end
                end
                default: state <= MM_IDLE;
            endcase
        end
    end

    // A[i][k] times each element of B row k
    assign a_elem = a_row_q[k_q];
    always_comb begin
        for (int j = 0; j < TILE_N; j++) begin
            // signed 8x8, sign-extended by the 32-bit target
            prod[j] = $signed(a_elem) * $signed(b_rd_data_i[j]);
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            c_q <= '0;
        end
        // A row is on the bus in the first B fetch of each row
        if (state == MM_FETCH_B && k_q == '0) begin
            a_row_q <= a_rd_data_i;
        end
        // B row k arrives one cycle after its fetch
        if (state == MM_ACCUM) begin
            for (int j = 0; j < TILE_N; j++) begin
                c_q[row_q][j] <= c_q[row_q][j] + prod[j];
            end
        end
    end

    assign a_rd_addr_o = row_q;
    assign b_rd_addr_o = k_q;
    assign c_tile_o    = c_q;
    assign done_o      = state == MM_DONE;

    // DMA only starts an idle or finished engine
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        start_i |-> (state == MM_IDLE || state == MM_DONE));

endmodule

/* hw/operand_buffer.sv */
// operand row buffer, four 32-bit rows
// one write port, one registered read port
module operand_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  gemm_pkg::buf_wr_t           wr_i,
    input  logic [gemm_pkg::BUF_AW-1:0] rd_addr_i,
    output gemm_pkg::row_t              rd_data_o
);
    import gemm_pkg::*;

    // row storage
    row_t rows_q [TILE_N];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TILE_N; i++) begin
                rows_q[i] <= '0;
            end
        end else if (wr_i.en) begin
            rows_q[wr_i.addr] <= wr_i.data;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data_o <= '0;
        end else begin
            // same-cycle write is not forwarded
            rd_data_o <= rows_q[rd_addr_i];
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# exit status is the simulator's status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f build.f --top-module gemm_tb -o gemm_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/gemm_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "simulation failed with status $sim_status"
    exit $sim_status
fi
exit 0

/* test/gemm_tb.sv */
// testbench for the GEMM accelerator
// directed tests against a reference 4x4 signed multiply
module gemm_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import gemm_pkg::*;

    // five runs of roughly 150 to 400 cycles each
    localparam int MAX_CYCLES = 3000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] mat_a_addr;
    logic [31:0] mat_b_addr;
    logic [31:0] mat_c_addr;
    logic        start;
    logic        done;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    logic [31:0] c_window;
    logic        bad_wr;

    // operands and expected product
    int a_m [TILE_N][TILE_N];
    int b_m [TILE_N][TILE_N];
    int c_exp [TILE_N][TILE_N];
    int c_first [TILE_N][TILE_N];
    int cycles = 0;
    // done pulses seen at sampled edges
    int done_seen = 0;

    always #20 clk = ~clk;

    gemm_accel_top i_gemm_accel_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (mat_a_addr),
        .mat_b_addr_i (mat_b_addr),
        .mat_c_addr_i (mat_c_addr),
        .start_i      (start),
        .done_o       (done),
        .mem_req_o    (mem_req),
        .mem_rsp_i    (mem_rsp)
    );

    mem_model u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .req_i    (mem_req),
        .rsp_o    (mem_rsp),
        .c_base_i (c_window),
        .bad_wr_o (bad_wr)
    );

    task automatic fail_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, run did not end within %0d cycles", MAX_CYCLES);
            fail_run();
        end
    end

    // stray write seen by the memory model
    always @(posedge clk) begin
        assert (bad_wr !== 1'b1) else begin
            $display("write request to an address outside the expected C words");
            fail_run();
        end
    end

    task automatic check_value(input string name, input int exp, input int act);
        assert (act == exp) else begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            fail_run();
        end
    endtask

    // one clock with done pulses counted on the way
    task automatic step_clock();
        @(posedge clk);
        if (done) begin
            done_seen++;
        end
    endtask

    // element 0 in the low byte
    function automatic logic [31:0] row_word(input bit from_b, input int r);
        logic [31:0] w;
        for (int k = 0; k < TILE_N; k++) begin
            w[8*k +: 8] = from_b ? 8'(b_m[r][k]) : 8'(a_m[r][k]);
        end
        return w;
    endfunction

    task automatic compute_reference();
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                c_exp[i][j] = 0;
                for (int k = 0; k < TILE_N; k++) begin
                    c_exp[i][j] += a_m[i][k] * b_m[k][j];
                end
            end
        end
    endtask

    task automatic random_operands();
        for (int i = 0; i < TILE_N; i++) begin
            for (int k = 0; k < TILE_N; k++) begin
                a_m[i][k] = int'($urandom_range(0, 255)) - 128;
                b_m[i][k] = int'($urandom_range(0, 255)) - 128;
            end
        end
        // both extremes always present
        a_m[0][0] = -128;
        a_m[3][2] = 127;
        b_m[0][1] = -128;
        b_m[3][3] = 127;
    endtask

    task automatic pulse_start();
        step_clock();
        start <= 1'b1;
        step_clock();
        start <= 1'b0;
    endtask

    // preload rows and point the DUT at them before the start pulse
    task automatic start_run(input logic [31:0] a_base, input logic [31:0] b_base,
                             input logic [31:0] c_base);
        for (int r = 0; r < TILE_N; r++) begin
            u_mem.write_word(a_base + 32'(4 * r), row_word(1'b0, r));
            u_mem.write_word(b_base + 32'(4 * r), row_word(1'b1, r));
        end
        mat_a_addr <= a_base;
        mat_b_addr <= b_base;
        mat_c_addr <= c_base;
        c_window   <= c_base;
        pulse_start();
    endtask

    task automatic wait_done();
        int n0;
        n0 = done_seen;
        while (done_seen == n0) begin
            step_clock();
        end
    endtask

    // C[i][j] at base + 4(4i + j)
    task automatic check_tile(input string name, input logic [31:0] c_base);
        logic [31:0] word;
        for (int i = 0; i < TILE_N; i++) begin
            for (int j = 0; j < TILE_N; j++) begin
                u_mem.read_word(c_base + 32'(4 * (4 * i + j)), word);
                check_value($sformatf("%s C[%0d][%0d]", name, i, j), c_exp[i][j], int'(word));
            end
        end
    endtask

    task automatic test_after_reset();
        for (int n = 0; n < 4; n++) begin
            step_clock();
            check_value("after_reset done_o", 0, int'(done));
            check_value("after_reset valid", 0, int'(mem_req.valid));
        end
    endtask

    task automatic test_identity();
        random_operands();
        for (int i = 0; i < TILE_N; i++) begin
            for (int k = 0; k < TILE_N; k++) begin
                a_m[i][k] = (i == k) ? 1 : 0;
            end
        end
        start_run(32'h000, 32'h040, 32'h080);
        wait_done();
        compute_reference();
        check_tile("test_identity", 32'h080);
    endtask

    task automatic test_random_signed();
        random_operands();
        start_run(32'h100, 32'h140, 32'h180);
        wait_done();
        compute_reference();
        check_tile("test_random_signed", 32'h180);
    endtask

    task automatic test_back_to_back();
        random_operands();
        start_run(32'h200, 32'h240, 32'h280);
        wait_done();
        compute_reference();
        c_first = c_exp;
        // second run with new operands and bases
        random_operands();
        start_run(32'h300, 32'h340, 32'h380);
        wait_done();
        compute_reference();
        check_tile("test_back_to_back second", 32'h380);
        c_exp = c_first;
        check_tile("test_back_to_back first", 32'h280);
    endtask

    task automatic test_start_ignored();
        int n0;
        random_operands();
        n0 = done_seen;
        start_run(32'h480, 32'h4c0, 32'h500);
        repeat (6) step_clock();
        // bogus bases that must not be latched
        mat_a_addr <= 32'h800;
        mat_b_addr <= 32'h840;
        mat_c_addr <= 32'h900;
        pulse_start();
        repeat (24) step_clock();
        pulse_start();
        mat_a_addr <= 32'h480;
        mat_b_addr <= 32'h4c0;
        mat_c_addr <= 32'h500;
        wait_done();
        // no second run may follow the ignored start pulses
        repeat (60) begin
            step_clock();
            check_value("test_start_ignored idle valid", 0, int'(mem_req.valid));
        end
        check_value("test_start_ignored done count", 1, done_seen - n0);
        compute_reference();
        check_tile("test_start_ignored", 32'h500);
    endtask

    initial begin
        void'($urandom(32'h21d1));
        rst_n      = 1'b0;
        start      = 1'b0;
        mat_a_addr = '0;
        mat_b_addr = '0;
        mat_c_addr = '0;
        c_window   = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_after_reset();
        test_identity();
        test_random_signed();
        test_back_to_back();
        test_start_ignored();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* test/mem_model.sv */
// memory slave for the testbench, 1024 words of 32 bits
// random ready, 1 to 4 cycle read latency
// flags any write outside the current C window
module mem_model (
    input  logic               clk,
    input  logic               rst_n,
    input  gemm_pkg::mem_req_t req_i,
    output gemm_pkg::mem_rsp_t rsp_o,
    input  logic [31:0]        c_base_i,
    output logic               bad_wr_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import gemm_pkg::*;

    logic [31:0] mem [1024];
    // read accepted, data still on its way
    logic        rd_busy;
    logic [1:0]  rd_wait;
    logic [31:0] rd_addr;
    logic        in_window;

    // C tile is 16 words from the base
    assign in_window = req_i.addr >= c_base_i && req_i.addr < c_base_i + 32'd64
                       && req_i.addr[1:0] == 2'b00;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_o    <= '0;
            rd_busy  <= 1'b0;
            rd_wait  <= '0;
            rd_addr  <= '0;
            bad_wr_o <= 1'b0;
        end else begin
            // ready with probability one half
            rsp_o.ready  <= $urandom_range(0, 1) == 1;
            rsp_o.rvalid <= 1'b0;
            if (req_i.valid && rsp_o.ready) begin
                if (req_i.we) begin
                    if (!in_window) begin
                        bad_wr_o <= 1'b1;
                    end
                    mem[req_i.addr[11:2]] <= req_i.wdata;
                end else begin
                    rd_busy <= 1'b1;
                    rd_addr <= req_i.addr;
                    // extra wait of 0 to 3 cycles
                    rd_wait <= 2'($urandom_range(0, 3));
                end
            end
            if (rd_busy) begin
                if (rd_wait == 2'd0) begin
                    rsp_o.rvalid <= 1'b1;
                    rsp_o.rdata  <= mem[rd_addr[11:2]];
                    rd_busy      <= 1'b0;
                end else begin
                    rd_wait <= rd_wait - 2'd1;
                end
            end
        end
    end

    // preload, takes effect at the end of the time step
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr[11:2]] <= data;
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        data = mem[addr[11:2]];
    endtask

endmodule
